//--- tb.f
verilog/fm_pkg.sv
verilog/fm_regs.sv
verilog/fm_clk_div.sv
verilog/fm_timer.sv
verilog/fm_timing_top.sv
tests/fm_timing_tb.sv

//--- tests/fm_timing_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fm_timing_tb;
    import fm_pkg::*;

    localparam int          NUM_TESTS = 7;
    localparam int          MARGIN    = 500;       // reset, writes, drain cycles
    localparam logic [31:0] SEED      = 32'h313a;
    localparam logic [7:0]  NO_PRE    = 8'h00;     // keep the current prescaler
    localparam int          TICK_CEN  = ADPCM_666_DIV * ADPCM_111_DIV;  // cen per 111 tick

    // timer control bytes
    localparam logic [7:0] CTL_A     = (8'd1 << CTL_LOAD_A) | (8'd1 << CTL_EN_A);
    localparam logic [7:0] CTL_B     = (8'd1 << CTL_LOAD_B) | (8'd1 << CTL_EN_B);
    localparam logic [7:0] CTL_B_OFF = (8'd1 << CTL_LOAD_B);  // runs with the flag masked
    localparam logic [7:0] CTL_CLR   = (8'd1 << CTL_RST_A) | (8'd1 << CTL_RST_B);

    typedef struct packed {
        logic [7:0] pre_addr;    // prescaler register or NO_PRE
        logic       rand_cen;    // cen from xorshift instead of always high
        logic [9:0] ta_val;
        logic [7:0] tb_val;
        logic [7:0] ctl;
        int         window;      // cen-high cycles
        int         op_div;      // expected operator divide
        int         ssg_div;     // expected SSG divide
        logic       exp_flag_a;
        logic       exp_flag_b;
        int         min_a;       // flag must not show up at or below this cen count
        int         min_b;
    } test_t;

    logic        clk;
    logic        rst_n;
    logic        cen;
    logic        wr;
    logic [7:0]  addr;
    logic [7:0]  din;
    logic        clk_en;
    logic        clk_en_ssg;
    logic        clk_en_666;
    logic        clk_en_111;
    logic        clk_en_55;
    logic        flag_a;
    logic        flag_b;
    logic        irq_n;

    test_t       tbl [NUM_TESTS];
    logic [31:0] rng;
    int          n_op;
    int          n_ssg;
    int          n_666;
    int          n_111;
    int          n_55;
    int          n_orphan;         // 55 pulses without a 111 pulse
    int          first_a;          // cen count when the flag was first seen
    int          first_b;
    int          cen_cnt;
    int          errors;
    int          passed;
    int          failed;
    int          cycle_cnt;
    int          cycle_limit = 0;  // 0 until the table is summed

    fm_timing_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cen        (cen),
        .wr         (wr),
        .addr       (addr),
        .din        (din),
        .clk_en     (clk_en),
        .clk_en_ssg (clk_en_ssg),
        .clk_en_666 (clk_en_666),
        .clk_en_111 (clk_en_111),
        .clk_en_55  (clk_en_55),
        .flag_a     (flag_a),
        .flag_b     (flag_b),
        .irq_n      (irq_n)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_limit == 0 || cycle_cnt <= cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run was still going after %0d cycles", cycle_limit);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fill_table;
        //           pre        rnd   ta      tb     ctl        win            N  ssg
        //           fa    fb    min_a          min_b
        tbl[0] = '{NO_PRE,    1'b0, 10'd0, 8'd0,   8'h00,     288,           6, 2,
                   1'b0, 1'b0, 0,             0};             // power-on DIV_6
        tbl[1] = '{REG_PRE_6, 1'b1, 10'd0, 8'd0,   8'h00,     288,           6, 2,
                   1'b0, 1'b0, 0,             0};
        tbl[2] = '{REG_PRE_3, 1'b0, 10'd0, 8'd0,   8'h00,     432,           3, 1,
                   1'b0, 1'b0, 0,             0};
        tbl[3] = '{REG_PRE_2, 1'b1, 10'd0, 8'd0,   8'h00,     432,           2, 1,
                   1'b0, 1'b0, 0,             0};
        tbl[4] = '{REG_PRE_6, 1'b0, 10'd1020, 8'd0, CTL_A,    4 * TICK_CEN,  6, 2,
                   1'b1, 1'b0, 3 * TICK_CEN,  0};             // 4 steps to overflow
        // 2 steps of 16 ticks
        // last tick comes at cen 31*72+1 at the earliest
        tbl[5] = '{REG_PRE_6, 1'b0, 10'd0, 8'd254, CTL_B,     32 * TICK_CEN, 6, 2,
                   1'b0, 1'b1, 0,             31 * TICK_CEN};
        tbl[6] = '{NO_PRE,    1'b0, 10'd0, 8'd254, CTL_B_OFF, 32 * TICK_CEN, 6, 2,
                   1'b0, 1'b0, 0,             0};             // overflows with the flag masked
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
        @(posedge clk);
        wr   <= 1'b1;
        addr <= a;
        din  <= d;
        @(posedge clk);  // captured on this edge
        wr   <= 1'b0;
    endtask

    task automatic check_eq(input int idx, input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("Mismatch at %0t ns: test %0d %s got %0d expected %0d",
                     $time, idx, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input int idx, input string name, input int first,
                              input logic now, input logic exp, input int min_cen);
        check_eq(idx, {name, " at window end"}, now, exp);
        if (exp) begin
            assert (first > min_cen) else begin
                $display("Mismatch at %0t ns: test %0d %s rose at cen %0d, expected after %0d",
                         $time, idx, name, first, min_cen);
                errors++;
            end
        end else begin
            check_eq(idx, {name, " seen during window"}, first >= 0, 0);
        end
    endtask

    // called at the falling edge where outputs are settled
    task automatic sample_outputs;
        if (clk_en) n_op++;
        if (clk_en_ssg) n_ssg++;
        if (clk_en_666) n_666++;
        if (clk_en_111) n_111++;
        if (clk_en_55) n_55++;
        if (clk_en_55 && !clk_en_111) n_orphan++;
        if (flag_a && first_a < 0) first_a = cen_cnt;
        if (flag_b && first_b < 0) first_b = cen_cnt;
    endtask

    task automatic run_window(input int idx);
        logic c;
        n_op     = 0;
        n_ssg    = 0;
        n_666    = 0;
        n_111    = 0;
        n_55     = 0;
        n_orphan = 0;
        first_a  = -1;
        first_b  = -1;
        cen_cnt  = 0;
        while (cen_cnt < tbl[idx].window) begin
            @(posedge clk);
            if (tbl[idx].rand_cen) begin
                rng = xorshift32(rng);
                c   = rng[7];
            end else begin
                c = 1'b1;
            end
            cen <= c;
            if (c) cen_cnt++;
            @(negedge clk);
            sample_outputs();
        end
        @(posedge clk);
        cen <= 1'b0;
        repeat (3) begin  // pick up pulses from the last cen cycles
            @(negedge clk);
            sample_outputs();
        end
    endtask

    task automatic check_results(input int idx);
        int win;
        win = tbl[idx].window;
        check_eq(idx, "clk_en pulses", n_op, win / tbl[idx].op_div);
        check_eq(idx, "clk_en_ssg pulses", n_ssg, win / tbl[idx].ssg_div);
        check_eq(idx, "clk_en_666 pulses", n_666, win / ADPCM_666_DIV);
        check_eq(idx, "clk_en_111 pulses", n_111, win / TICK_CEN);
        check_eq(idx, "clk_en_55 pulses", n_55, win / (TICK_CEN * ADPCM_55_DIV));
        check_eq(idx, "clk_en_55 without clk_en_111", n_orphan, 0);
        check_flag(idx, "flag_a", first_a, flag_a, tbl[idx].exp_flag_a, tbl[idx].min_a);
        check_flag(idx, "flag_b", first_b, flag_b, tbl[idx].exp_flag_b, tbl[idx].min_b);
        check_eq(idx, "irq_n", irq_n, !(tbl[idx].exp_flag_a || tbl[idx].exp_flag_b));
    endtask

    initial begin
        int err_before;
        rst_n  = 1'b0;
        cen    = 1'b0;
        wr     = 1'b0;
        addr   = 8'h00;
        din    = 8'h00;
        rng    = SEED;
        errors = 0;
        passed = 0;
        failed = 0;
        fill_table();
        cycle_limit = MARGIN + NUM_TESTS * 20;
        for (int i = 0; i < NUM_TESTS; i++) begin
            cycle_limit += 3 * tbl[i].window;  // random cen runs about half the time
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // nothing may move while cen is still low
        err_before = errors;
        repeat (8) begin
            @(negedge clk);
            check_eq(-1, "enables before cen",
                     {clk_en, clk_en_ssg, clk_en_666, clk_en_111, clk_en_55}, 0);
            check_eq(-1, "flags before cen", {flag_a, flag_b}, 0);
            check_eq(-1, "irq_n before cen", irq_n, 1);
        end
        if (errors == err_before) begin
            $display("idle check passed");
            passed++;
        end else begin
            $display("idle check failed");
            failed++;
        end

        for (int i = 0; i < NUM_TESTS; i++) begin
            err_before = errors;
            if (tbl[i].pre_addr != NO_PRE) begin
                write_reg(tbl[i].pre_addr, 8'h00);  // data ignored
            end
            write_reg(REG_TA_HI, tbl[i].ta_val[9:2]);
            write_reg(REG_TA_LO, {6'd0, tbl[i].ta_val[1:0]});
            write_reg(REG_TB, tbl[i].tb_val);
            write_reg(REG_TIMER_CTL, tbl[i].ctl);
            run_window(i);
            check_results(i);
            // flag reset also stops the timers
            write_reg(REG_TIMER_CTL, CTL_CLR);
            repeat (2) @(negedge clk);
            check_eq(i, "flag_a after reset write", flag_a, 0);
            check_eq(i, "flag_b after reset write", flag_b, 0);
            check_eq(i, "irq_n after reset write", irq_n, 1);
            if (errors == err_before) begin
                $display("test %0d passed", i);
                passed++;
            end else begin
                $display("test %0d failed with %0d errors", i, errors - err_before);
                failed++;
            end
        end

        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/fm_clk_div.sv
`timescale 1ns/1ps
`default_nettype none

module fm_clk_div (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cen,         // master clock gate
    input  fm_pkg::div_sel_e div_sel,     // prescaler from reg block
    output logic             clk_en,      // operator enable
    output logic             clk_en_ssg,  // SSG enable
    output logic             clk_en_666,  // 666 kHz
    output logic             clk_en_111,  // 111 kHz, also timer tick
    output logic             clk_en_55    // 55 kHz
);
    import fm_pkg::*;

    logic [3:0] opn_cnt;   // operator divider
    logic [3:0] opn_last;  // N-1
    logic [2:0] ssg_cnt;
    logic [2:0] ssg_last;
    logic [4:0] cnt_666;   // ADPCM-A cascade
    logic [2:0] cnt_111;
    logic [2:0] cnt_55;
    logic       zero_666;
    logic       zero_111;
    logic       zero_55;

    // wrap points per prescaler choice
    always_comb begin
        case (div_sel)
            DIV_2: begin
                opn_last = 4'd1;
                ssg_last = 3'd0;  // SSG every cen
            end
            DIV_3: begin
                opn_last = 4'd2;
                ssg_last = 3'd0;
            end
            default: begin  // DIV_6, spare code too
                opn_last = 4'd5;
                ssg_last = 3'd1;  // SSG every 2nd cen
            end
        endcase
    end

    assign zero_666 = (cnt_666 == 5'd0);
    assign zero_111 = (cnt_111 == 3'd0);
    assign zero_55  = (cnt_55 == 3'd0);

    // operator and SSG counters
    // >= so a smaller N chosen mid-count wraps on the next cen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opn_cnt <= 4'd0;
            ssg_cnt <= 3'd0;
        end else if (cen) begin
            opn_cnt <= (opn_cnt >= opn_last) ? 4'd0 : opn_cnt + 4'd1;
            ssg_cnt <= (ssg_cnt >= ssg_last) ? 3'd0 : ssg_cnt + 3'd1;
        end
    end

    // ADPCM-A rates, each stage steps when the ones above are at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_666 <= 5'd0;
            cnt_111 <= 3'd0;
            cnt_55  <= 3'd0;
        end else if (cen) begin
            cnt_666 <= (cnt_666 == 5'(ADPCM_666_DIV - 1)) ? 5'd0 : cnt_666 + 5'd1;
            if (zero_666) begin
                cnt_111 <= (cnt_111 == 3'(ADPCM_111_DIV - 1)) ? 3'd0 : cnt_111 + 3'd1;
                if (zero_111) begin
                    cnt_55 <= (cnt_55 == 3'(ADPCM_55_DIV - 1)) ? 3'd0 : cnt_55 + 3'd1;
                end
            end
        end
    end

    // registered enables, one clock wide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_en     <= 1'b0;
            clk_en_ssg <= 1'b0;
            clk_en_666 <= 1'b0;
            clk_en_111 <= 1'b0;
            clk_en_55  <= 1'b0;
        end else begin
            clk_en     <= cen && (opn_cnt == 4'd0);
            clk_en_ssg <= cen && (ssg_cnt == 3'd0);
            clk_en_666 <= cen && zero_666;
            clk_en_111 <= cen && zero_666 && zero_111;
            clk_en_55  <= cen && zero_666 && zero_111 && zero_55;
        end
    end

    // slower rates only ever fire together with the faster ones
    a_55_in_111: assert property (@(posedge clk) disable iff (!rst_n)
        clk_en_55 |-> clk_en_111)
        else $error("clk_en_55 without clk_en_111");

    a_111_in_666: assert property (@(posedge clk) disable iff (!rst_n)
        clk_en_111 |-> clk_en_666)
        else $error("clk_en_111 without clk_en_666");

    // a gated master clock produces no enables at all
    a_cen_gate: assert property (@(posedge clk) disable iff (!rst_n)
        !cen |=> !(clk_en || clk_en_ssg || clk_en_666 || clk_en_111 || clk_en_55))
        else $error("enable pulse after a cen-low cycle");

endmodule

`default_nettype wire

//--- verilog/fm_pkg.sv
`default_nettype none

package fm_pkg;

    // host register map of the timer block
    typedef enum logic [7:0] {
        REG_TA_HI     = 8'h24,  // timer A bits 9..2
        REG_TA_LO     = 8'h25,  // timer A bits 1..0
        REG_TB        = 8'h26,  // timer B, full byte
        REG_TIMER_CTL = 8'h27,  // load / enable / flag reset
        REG_PRE_6     = 8'h2d,  // prescaler /6
        REG_PRE_3     = 8'h2e,  // prescaler /3
        REG_PRE_2     = 8'h2f   // prescaler /2
    } reg_addr_e;

    // operator clock divide choice
    typedef enum logic [1:0] {
        DIV_2 = 2'd0,
        DIV_3 = 2'd1,
        DIV_6 = 2'd2   // YM2608 power-on value
    } div_sel_e;

    localparam int TA_W   = 10;  // timer A counter bits
    localparam int TB_W   = 8;   // timer B counter bits
    localparam int TB_PRE = 16;  // 111 kHz ticks per timer B step

    // ADPCM-A enable cascade, in cen cycles / parent pulses
    localparam int ADPCM_666_DIV = 12;
    localparam int ADPCM_111_DIV = 6;
    localparam int ADPCM_55_DIV  = 2;

    // bit positions in the timer control byte (reg 0x27)
    localparam int CTL_LOAD_A = 0;
    localparam int CTL_LOAD_B = 1;
    localparam int CTL_EN_A   = 2;
    localparam int CTL_EN_B   = 3;
    localparam int CTL_RST_A  = 4;
    localparam int CTL_RST_B  = 5;

endpackage

`default_nettype wire

//--- verilog/fm_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fm_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr,          // write strobe
    input  logic [7:0]                addr,
    input  logic [7:0]                din,
    output fm_pkg::div_sel_e          div_sel,     // to divider
    output logic [fm_pkg::TA_W-1:0]   ta_value,
    output logic [fm_pkg::TB_W-1:0]   tb_value,
    output logic                      load_a,      // levels, straight from reg 0x27
    output logic                      load_b,
    output logic                      flag_en_a,
    output logic                      flag_en_b,
    output logic                      flag_rst_a,  // one-cycle pulses
    output logic                      flag_rst_b
);
    import fm_pkg::*;

    logic ctl_wr;  // control byte written this edge

    assign ctl_wr = wr && (addr == REG_TIMER_CTL);

    // register file, writes land every cycle regardless of cen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_sel   <= DIV_6;
            ta_value  <= '0;
            tb_value  <= '0;
            load_a    <= 1'b0;
            load_b    <= 1'b0;
            flag_en_a <= 1'b0;
            flag_en_b <= 1'b0;
        end else if (wr) begin
            case (addr)
                REG_TA_HI: begin
                    ta_value[TA_W-1:2] <= din;  // upper 8 bits
                end
                REG_TA_LO: begin
                    ta_value[1:0] <= din[1:0];  // rest of the byte unused
                end
                REG_TB: begin
                    tb_value <= din;
                end
                REG_TIMER_CTL: begin
                    load_a    <= din[CTL_LOAD_A];
                    load_b    <= din[CTL_LOAD_B];
                    flag_en_a <= din[CTL_EN_A];
                    flag_en_b <= din[CTL_EN_B];
                end
                // prescaler regs are address-only, data ignored
                REG_PRE_6: begin
                    div_sel <= DIV_6;
                end
                REG_PRE_3: begin
                    div_sel <= DIV_3;
                end
                REG_PRE_2: begin
                    div_sel <= DIV_2;
                end
                default: begin
                    // other addresses belong to blocks not modelled here
                end
            endcase
        end
    end

    // flag reset bits are write-only strobes
    // back-to-back reset writes merge into one pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_rst_a <= 1'b0;
            flag_rst_b <= 1'b0;
        end else begin
            flag_rst_a <= ctl_wr && din[CTL_RST_A] && !flag_rst_a;
            flag_rst_b <= ctl_wr && din[CTL_RST_B] && !flag_rst_b;
        end
    end

    // timers see a clean single-cycle reset even under repeated writes
    a_rst_a_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        flag_rst_a |=> !flag_rst_a)
        else $error("flag_rst_a held for more than one cycle");

    a_rst_b_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        flag_rst_b |=> !flag_rst_b)
        else $error("flag_rst_b held for more than one cycle");

endmodule

`default_nettype wire

//--- verilog/fm_timer.sv
`timescale 1ns/1ps
`default_nettype none

module fm_timer #(
    parameter int W   = 10,  // counter width
    parameter int PRE = 1    // ticks per count step
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         tick,      // 111 kHz enable
    input  logic         load,      // level, counting while high
    input  logic [W-1:0] value,     // reload value
    input  logic         flag_en,
    input  logic         flag_rst,  // one-cycle clear
    output logic         flag
);
    logic         load_q;   // load seen on the previous edge
    logic         running;  // loaded and counting
    logic         step;     // one count
    logic         ovf;      // step from all ones
    logic [W-1:0] cnt;

    assign running = load && load_q;

    generate
        if (PRE > 1) begin : g_pre
            logic [$clog2(PRE)-1:0] pre_cnt;
            logic                   pre_wrap;

            assign pre_wrap = (int'(pre_cnt) == PRE - 1);

            // tick prescaler, restarts with every load
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    pre_cnt <= '0;
                end else if (!running) begin
                    pre_cnt <= '0;
                end else if (tick) begin
                    pre_cnt <= pre_wrap ? '0 : pre_cnt + 1'b1;
                end
            end

            assign step = running && tick && pre_wrap;
        end else begin : g_no_pre
            assign step = running && tick;  // timer A counts every tick
        end
    endgenerate

    assign ovf = step && (&cnt);

    // up-counter, tracks value until load has been high for an edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_q <= 1'b0;
            cnt    <= '0;
        end else begin
            load_q <= load;
            if (!running) begin
                cnt <= value;
            end else if (step) begin
                cnt <= ovf ? value : cnt + 1'b1;  // period is 2^W - value steps
            end
        end
    end

    // overflow flag, set beats clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag <= 1'b0;
        end else if (ovf && flag_en) begin
            flag <= 1'b1;
        end else if (flag_rst) begin
            flag <= 1'b0;
        end
    end

    // a masked timer keeps overflowing but never raises its flag
    a_flag_masked: assert property (@(posedge clk) disable iff (!rst_n)
        (!flag_en && !flag) |=> !flag)
        else $error("timer flag rose while flag_en was low");

endmodule

`default_nettype wire

//--- verilog/fm_timing_top.sv
`timescale 1ns/1ps
`default_nettype none

module fm_timing_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,         // master clock gate
    input  logic       wr,          // host write strobe
    input  logic [7:0] addr,
    input  logic [7:0] din,
    output logic       clk_en,      // operator enable
    output logic       clk_en_ssg,
    output logic       clk_en_666,  // ADPCM-A rates
    output logic       clk_en_111,
    output logic       clk_en_55,
    output logic       flag_a,      // timer status
    output logic       flag_b,
    output logic       irq_n        // open-drain style, low active
);
    import fm_pkg::*;

    div_sel_e          div_sel;
    logic [TA_W-1:0]   ta_value;
    logic [TB_W-1:0]   tb_value;
    logic              load_a;
    logic              load_b;
    logic              flag_en_a;
    logic              flag_en_b;
    logic              flag_rst_a;
    logic              flag_rst_b;

    // host side
    fm_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (wr),
        .addr       (addr),
        .din        (din),
        .div_sel    (div_sel),
        .ta_value   (ta_value),
        .tb_value   (tb_value),
        .load_a     (load_a),
        .load_b     (load_b),
        .flag_en_a  (flag_en_a),
        .flag_en_b  (flag_en_b),
        .flag_rst_a (flag_rst_a),
        .flag_rst_b (flag_rst_b)
    );

    fm_clk_div u_div (
        .clk        (clk),
        .rst_n      (rst_n),
        .cen        (cen),
        .div_sel    (div_sel),
        .clk_en     (clk_en),
        .clk_en_ssg (clk_en_ssg),
        .clk_en_666 (clk_en_666),
        .clk_en_111 (clk_en_111),
        .clk_en_55  (clk_en_55)
    );

    // timer A, one count per 111 kHz tick
    fm_timer #(.W(TA_W), .PRE(1)) u_timer_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .tick     (clk_en_111),
        .load     (load_a),
        .value    (ta_value),
        .flag_en  (flag_en_a),
        .flag_rst (flag_rst_a),
        .flag     (flag_a)
    );

    // timer B, 16x slower
    fm_timer #(.W(TB_W), .PRE(TB_PRE)) u_timer_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .tick     (clk_en_111),
        .load     (load_b),
        .value    (tb_value),
        .flag_en  (flag_en_b),
        .flag_rst (flag_rst_b),
        .flag     (flag_b)
    );

    assign irq_n = !(flag_a || flag_b);  // either flag pulls the line low

endmodule

`default_nettype wire
